// File: logic/ahb_endpoint_macros.svh
// AHB-Lite endpoint slave shared constants
// Bus widths, address map of the endpoint and status word field positions

`ifndef AHB_ENDPOINT_MACROS_SVH
`define AHB_ENDPOINT_MACROS_SVH

// ******************************
// Bus widths
`define AHB_ADDR_W 7
`define AHB_DATA_W 32

// ******************************
// Address map
// Data buffer window starts at zero
`define EP_BUF_TOP      7'h3F
// Status word covers four bytes from here
`define EP_STATUS_BASE  7'h40
`define EP_TX_SIZE_ADDR 7'h48

// Occupancy and transfer size width
`define EP_OCC_W 7

// Status word bits
`define EP_ST_RX_READY_BIT  0
`define EP_ST_RX_ACTIVE_BIT 1
`define EP_ST_TX_ACTIVE_BIT 2
`define EP_ST_RX_ERR_BIT    8
`define EP_ST_TX_ERR_BIT    9
// Buffer occupancy field, EP_OCC_W bits wide
`define EP_ST_OCC_LSB       16

`endif

// File: logic/ahb_endpoint_pkg.sv
// AHB-Lite endpoint slave package
// Transfer codes, sizes and the decoded data-phase target

`include "ahb_endpoint_macros.svh"

package ahb_endpoint_pkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE = 2'd0,
    // Treated like IDLE by this slave
    HTRANS_BUSY = 2'd1,
    HTRANS_NSEQ = 2'd2,
    HTRANS_SEQ  = 2'd3
  } htrans_t;

  // HSIZE, low two bits only
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    // Wider than the bus, always answered with an error
    SIZE_DWORD = 2'd3
  } hsize_t;

  // Target of the pending data phase
  typedef enum logic [2:0] {
    REGION_NONE    = 3'd0,
    REGION_BUFFER  = 3'd1,
    REGION_STATUS  = 3'd2,
    REGION_TX_SIZE = 3'd3,
    REGION_ERROR   = 3'd4
  } region_t;

  // Last byte address of the status word
  localparam logic [`AHB_ADDR_W-1:0] STATUS_TOP = `EP_STATUS_BASE + 7'd3;

endpackage

// File: logic/ahb_addr_phase.sv
// AHB-Lite address phase sampler
// Accepts NSEQ/SEQ beats, decodes the target region and the error cases,
// and holds write, size and byte offset for the data phase

`timescale 1ns/100ps

`include "ahb_endpoint_macros.svh"

module ahb_addr_phase (
  input  logic                     tb_clk,
  input  logic                     reset_i,
  input  logic                     hsel_i,
  input  logic [`AHB_ADDR_W-1:0]   haddr_i,
  input  ahb_endpoint_pkg::htrans_t htrans_i,
  input  ahb_endpoint_pkg::hsize_t  hsize_i,
  input  logic                     hwrite_i,
  input  logic                     hready_i,
  output ahb_endpoint_pkg::region_t dp_region_o,
  output logic                     dp_write_o,
  output ahb_endpoint_pkg::hsize_t  dp_size_o,
  output logic [1:0]               dp_offset_o
);

  import ahb_endpoint_pkg::*;

  logic    accept;
  logic    misaligned;
  region_t addr_region;

  // Address phase taken only on active beats, BUSY counts as idle
  assign accept = hready_i && hsel_i &&
                  ((htrans_i == HTRANS_NSEQ) || (htrans_i == HTRANS_SEQ));

  // ******************************
  // Region decode
  always_comb begin
    // Halfword needs bit 0 clear, word needs both low bits clear
    case (hsize_i)
      SIZE_HALF: misaligned = haddr_i[0];
      SIZE_WORD: misaligned = |haddr_i[1:0];
      default:   misaligned = 1'b0;
    endcase

    // Anything outside the map is an error
    addr_region = REGION_ERROR;
    if (haddr_i <= `EP_BUF_TOP) begin
      addr_region = REGION_BUFFER;
    end else if ((haddr_i >= `EP_STATUS_BASE) && (haddr_i <= STATUS_TOP)) begin
      // Status block is read only
      addr_region = hwrite_i ? REGION_ERROR : REGION_STATUS;
    end else if (haddr_i == `EP_TX_SIZE_ADDR) begin
      addr_region = REGION_TX_SIZE;
    end

    // 64-bit and misaligned beats override the map
    if ((hsize_i == SIZE_DWORD) || misaligned) begin
      addr_region = REGION_ERROR;
    end
  end

  // ******************************
  // Data phase context
  always_ff @(posedge tb_clk) begin
    if (reset_i) begin
      dp_region_o <= REGION_NONE;
      dp_write_o  <= 1'b0;
      dp_size_o   <= SIZE_BYTE;
      dp_offset_o <= 2'b00;
    end else if (hready_i) begin
      if (accept) begin
        dp_region_o <= addr_region;
        dp_write_o  <= hwrite_i;
        dp_size_o   <= hsize_i;
        dp_offset_o <= haddr_i[1:0];
      end else begin
        // Idle slot, nothing pending next cycle
        dp_region_o <= REGION_NONE;
        dp_write_o  <= 1'b0;
      end
    end
    // Stalled data phase keeps its context
  end

  // Aligned word read of the status base must reach the status block
  a_status_read_ok : assert property (
    @(posedge tb_clk) disable iff (reset_i)
    (accept && !hwrite_i && (hsize_i == SIZE_WORD) && (haddr_i == `EP_STATUS_BASE))
      |=> (dp_region_o == REGION_STATUS)
  );

endmodule

// File: logic/ahb_resp_ctrl.sv
// AHB-Lite response generator
// Answers good data phases OKAY with no wait states and runs the
// two-cycle ERROR response for erroneous ones

`timescale 1ns/100ps

module ahb_resp_ctrl (
  input  logic                      tb_clk,
  input  logic                      reset_i,
  input  ahb_endpoint_pkg::region_t dp_region_i,
  output logic                      hready_o,
  output logic                      hresp_o
);

  import ahb_endpoint_pkg::*;

  typedef enum logic [1:0] {
    RESP_OKAY       = 2'd0,
    RESP_ERR_FIRST  = 2'd1,
    RESP_ERR_SECOND = 2'd2
  } resp_state_t;

  resp_state_t state_q;
  resp_state_t resp_state;

  // First error cycle is the one where the error region appears,
  // so it is seen directly rather than waiting for a register
  assign resp_state = ((state_q == RESP_OKAY) && (dp_region_i == REGION_ERROR)) ?
                      RESP_ERR_FIRST : state_q;

  always_ff @(posedge tb_clk) begin
    if (reset_i) begin
      state_q <= RESP_OKAY;
    end else begin
      case (resp_state)
        RESP_ERR_FIRST:  state_q <= RESP_ERR_SECOND;
        // Region moves on at this edge
        default:         state_q <= RESP_OKAY;
      endcase
    end
  end

  // Wait only in the first error cycle, flag error in both
  assign hready_o = (resp_state != RESP_ERR_FIRST);
  assign hresp_o  = (resp_state != RESP_OKAY);

  // Second error cycle always follows the first
  a_err_second : assert property (
    @(posedge tb_clk) disable iff (reset_i)
    (resp_state == RESP_ERR_FIRST) |=> (hready_o && hresp_o)
  );

  // ERROR must start with a wait cycle
  a_err_start_wait : assert property (
    @(posedge tb_clk) disable iff (reset_i)
    $rose(hresp_o) |-> !hready_o
  );

endmodule

// File: logic/endpoint_regs.sv
// Endpoint side of the AHB-Lite slave
// Transfer size register with buffer reservation, buffer store and
// fetch strobes, and the read data mux for buffer, status and size

`timescale 1ns/100ps

`include "ahb_endpoint_macros.svh"

module endpoint_regs (
  input  logic                      tb_clk,
  input  logic                      reset_i,
  input  ahb_endpoint_pkg::region_t dp_region_i,
  input  logic                      dp_write_i,
  input  ahb_endpoint_pkg::hsize_t  dp_size_i,
  input  logic [1:0]                dp_offset_i,
  input  logic                      hready_i,
  input  logic [`AHB_DATA_W-1:0]    hwdata_i,
  input  logic                      rx_data_ready_i,
  input  logic                      rx_transfer_active_i,
  input  logic                      tx_transfer_active_i,
  input  logic                      rx_error_i,
  input  logic                      tx_error_i,
  input  logic [`EP_OCC_W-1:0]      buffer_occupancy_i,
  input  logic [`AHB_DATA_W-1:0]    rx_data_i,
  output logic [`AHB_DATA_W-1:0]    hrdata_o,
  output logic                      store_tx_data_o,
  output logic [`AHB_DATA_W-1:0]    tx_data_o,
  output logic [1:0]                data_size_o,
  output logic                      get_rx_data_o,
  output logic                      buffer_reserved_o,
  output logic [`EP_OCC_W-1:0]      tx_packet_data_size_o
);

  import ahb_endpoint_pkg::*;

  logic [`EP_OCC_W-1:0]   tx_size_q;
  logic                   reserved_q;
  logic                   tx_active_q;
  logic                   tx_end;
  logic                   size_wr;
  logic [4:0]             lane_shift;
  logic [`AHB_DATA_W-1:0] status_word;

  // Byte offset to bit shift
  assign lane_shift = {dp_offset_i, 3'b000};

  // ******************************
  // Buffer strobes, one per completed data phase
  assign store_tx_data_o = (dp_region_i == REGION_BUFFER) && dp_write_i && hready_i;
  assign get_rx_data_o   = (dp_region_i == REGION_BUFFER) && !dp_write_i && hready_i;
  // Buffer takes write data LSB aligned
  assign tx_data_o       = hwdata_i >> lane_shift;
  assign data_size_o     = dp_size_i;

  // ******************************
  // Transfer size register
  // Outgoing transfer ends on the falling edge of tx active
  assign tx_end  = tx_active_q && !tx_transfer_active_i;
  assign size_wr = (dp_region_i == REGION_TX_SIZE) && dp_write_i && hready_i;

  always_ff @(posedge tb_clk) begin
    if (reset_i) begin
      tx_active_q <= 1'b0;
      tx_size_q   <= '0;
      reserved_q  <= 1'b0;
    end else begin
      tx_active_q <= tx_transfer_active_i;
      if (tx_end) begin
        // End of transfer wins over a write in the same cycle
        tx_size_q  <= '0;
        reserved_q <= 1'b0;
      end else if (size_wr) begin
        // Register sits on byte lane 0
        tx_size_q  <= hwdata_i[`EP_OCC_W-1:0];
        reserved_q <= |hwdata_i[`EP_OCC_W-1:0];
      end
    end
  end

  assign buffer_reserved_o     = reserved_q;
  assign tx_packet_data_size_o = tx_size_q;

  // ******************************
  // Read data
  always_comb begin
    status_word = '0;
    status_word[`EP_ST_RX_READY_BIT]  = rx_data_ready_i;
    status_word[`EP_ST_RX_ACTIVE_BIT] = rx_transfer_active_i;
    status_word[`EP_ST_TX_ACTIVE_BIT] = tx_transfer_active_i;
    status_word[`EP_ST_RX_ERR_BIT]    = rx_error_i;
    status_word[`EP_ST_TX_ERR_BIT]    = tx_error_i;
    status_word[`EP_ST_OCC_LSB +: `EP_OCC_W] = buffer_occupancy_i;
  end

  always_comb begin
    case (dp_region_i)
      // Buffer word comes LSB aligned, move it onto its lanes
      REGION_BUFFER:  hrdata_o = rx_data_i << lane_shift;
      REGION_STATUS:  hrdata_o = status_word;
      REGION_TX_SIZE: hrdata_o = {{(`AHB_DATA_W-`EP_OCC_W){1'b0}}, tx_size_q};
      default:        hrdata_o = '0;
    endcase
  end

  // Store and fetch never overlap
  a_strobe_excl : assert property (
    @(posedge tb_clk) disable iff (reset_i)
    store_tx_data_o |-> !get_rx_data_o
  );

endmodule

// File: logic/ahb_endpoint_slave.sv
// AHB-Lite slave for a USB endpoint
// Top level joining the address phase sampler, the response generator
// and the endpoint registers

`timescale 1ns/100ps

`include "ahb_endpoint_macros.svh"

module ahb_endpoint_slave (
  input  logic                      tb_clk,
  input  logic                      reset_i,
  // AHB from the master
  input  logic                      hsel_i,
  input  logic [`AHB_ADDR_W-1:0]    haddr_i,
  input  ahb_endpoint_pkg::htrans_t htrans_i,
  input  ahb_endpoint_pkg::hsize_t  hsize_i,
  input  logic                      hwrite_i,
  input  logic [`AHB_DATA_W-1:0]    hwdata_i,
  // AHB to the master
  output logic [`AHB_DATA_W-1:0]    hrdata_o,
  output logic                      hready_o,
  output logic                      hresp_o,
  // Endpoint status
  input  logic                      rx_data_ready_i,
  input  logic                      rx_transfer_active_i,
  input  logic                      tx_transfer_active_i,
  input  logic                      rx_error_i,
  input  logic                      tx_error_i,
  input  logic [`EP_OCC_W-1:0]      buffer_occupancy_i,
  input  logic [`AHB_DATA_W-1:0]    rx_data_i,
  // Endpoint controls
  output logic                      store_tx_data_o,
  output logic [`AHB_DATA_W-1:0]    tx_data_o,
  output logic [1:0]                data_size_o,
  output logic                      get_rx_data_o,
  output logic                      buffer_reserved_o,
  output logic [`EP_OCC_W-1:0]      tx_packet_data_size_o
);

  import ahb_endpoint_pkg::*;

  // Data phase context
  region_t    dp_region;
  logic       dp_write;
  hsize_t     dp_size;
  logic [1:0] dp_offset;

  ahb_addr_phase addr_phase_i (
    .tb_clk      (tb_clk),
    .reset_i     (reset_i),
    .hsel_i      (hsel_i),
    .haddr_i     (haddr_i),
    .htrans_i    (htrans_i),
    .hsize_i     (hsize_i),
    .hwrite_i    (hwrite_i),
    .hready_i    (hready_o),
    .dp_region_o (dp_region),
    .dp_write_o  (dp_write),
    .dp_size_o   (dp_size),
    .dp_offset_o (dp_offset)
  );

  // Drives HREADY for the bus and for both other blocks
  ahb_resp_ctrl resp_ctrl_i (
    .tb_clk      (tb_clk),
    .reset_i     (reset_i),
    .dp_region_i (dp_region),
    .hready_o    (hready_o),
    .hresp_o     (hresp_o)
  );

  endpoint_regs regs_i (
    .tb_clk                (tb_clk),
    .reset_i               (reset_i),
    .dp_region_i           (dp_region),
    .dp_write_i            (dp_write),
    .dp_size_i             (dp_size),
    .dp_offset_i           (dp_offset),
    .hready_i              (hready_o),
    .hwdata_i              (hwdata_i),
    .rx_data_ready_i       (rx_data_ready_i),
    .rx_transfer_active_i  (rx_transfer_active_i),
    .tx_transfer_active_i  (tx_transfer_active_i),
    .rx_error_i            (rx_error_i),
    .tx_error_i            (tx_error_i),
    .buffer_occupancy_i    (buffer_occupancy_i),
    .rx_data_i             (rx_data_i),
    .hrdata_o              (hrdata_o),
    .store_tx_data_o       (store_tx_data_o),
    .tx_data_o             (tx_data_o),
    .data_size_o           (data_size_o),
    .get_rx_data_o         (get_rx_data_o),
    .buffer_reserved_o     (buffer_reserved_o),
    .tx_packet_data_size_o (tx_packet_data_size_o)
  );

endmodule

// File: dv/tb_ahb_endpoint_tasks.svh
// AHB-Lite bus tasks and directed tests for the endpoint slave
// Included into the testbench top, uses its signals and check task

// ******************************
// Bus tasks
// Returns at the negedge of a cycle with HREADY high
task automatic wait_ready(input string what);
  int   cycles;
  logic done;
  cycles = 0;
  done   = 1'b0;
  while (!done) begin
    @(negedge tb_clk);
    done = hready_o;
    if (!done) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("Timeout: HREADY stayed low during %s", what));
      end
    end
  end
endtask

// One single transfer, strobes counted over every data-phase cycle
task automatic ahb_transfer(input logic [`AHB_ADDR_W-1:0] addr, input logic write,
                            input hsize_t size, input logic [31:0] wdata,
                            output logic resp);
  int   cycles;
  logic done;
  cycles      = 0;
  done        = 1'b0;
  store_count = 0;
  get_count   = 0;
  @(posedge tb_clk);
  hsel_i   <= 1'b1;
  haddr_i  <= addr;
  htrans_i <= HTRANS_NSEQ;
  hsize_i  <= size;
  hwrite_i <= write;
  wait_ready("address phase");
  // Address accepted here, data follows
  @(posedge tb_clk);
  hsel_i   <= 1'b0;
  htrans_i <= HTRANS_IDLE;
  hwdata_i <= wdata;
  while (!done) begin
    @(negedge tb_clk);
    if (store_tx_data_o) store_count++;
    if (get_rx_data_o) get_count++;
    done = hready_o;
    if (!done) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        abort_run("Timeout: data phase never completed");
      end
    end
  end
  // Data-phase cycles with HREADY low
  seen_waits   = cycles;
  resp         = hresp_o;
  seen_rdata   = hrdata_o;
  seen_tx_data = tx_data_o;
  seen_size    = data_size_o;
endtask

task automatic ahb_write(input logic [`AHB_ADDR_W-1:0] addr, input hsize_t size,
                         input logic [31:0] wdata, output logic resp);
  ahb_transfer(addr, 1'b1, size, wdata, resp);
endtask

task automatic ahb_read(input logic [`AHB_ADDR_W-1:0] addr, input hsize_t size,
                        output logic [31:0] rdata, output logic resp);
  ahb_transfer(addr, 1'b0, size, 32'd0, resp);
  rdata = seen_rdata;
endtask

// Four pipelined word writes, NSEQ then SEQ
task automatic ahb_burst_write(input logic [`AHB_ADDR_W-1:0] base);
  @(posedge tb_clk);
  hsel_i   <= 1'b1;
  haddr_i  <= base;
  htrans_i <= HTRANS_NSEQ;
  hsize_i  <= SIZE_WORD;
  hwrite_i <= 1'b1;
  wait_ready("burst address phase");
  for (int i = 0; i < 4; i++) begin
    @(posedge tb_clk);
    if (i < 3) begin
      // Next beat address overlaps this data phase
      haddr_i  <= base + 7'(4 * (i + 1));
      htrans_i <= HTRANS_SEQ;
    end else begin
      hsel_i   <= 1'b0;
      htrans_i <= HTRANS_IDLE;
    end
    hwdata_i <= burst_words[i];
    wait_ready("burst data phase");
    beat_store[i] = store_tx_data_o;
    beat_tx[i]    = tx_data_o;
    beat_resp[i]  = hresp_o;
  end
endtask

// ******************************
// Directed tests
task automatic reset_state_test();
  @(negedge tb_clk);
  check_value("reset hready", 32'd1, {31'd0, hready_o});
  check_value("reset hresp", 32'd0, {31'd0, hresp_o});
  check_value("reset store strobe", 32'd0, {31'd0, store_tx_data_o});
  check_value("reset fetch strobe", 32'd0, {31'd0, get_rx_data_o});
  check_value("reset reservation", 32'd0, {31'd0, buffer_reserved_o});
  check_value("reset tx size", 32'd0, {25'd0, tx_packet_data_size_o});
endtask

// Every size at every aligned offset
task automatic buffer_write_test();
  logic [31:0] data;
  logic [31:0] rnd;
  logic        resp;
  for (int sz = 0; sz < 3; sz++) begin
    for (int off = 0; off < 4; off += (1 << sz)) begin
      data = lfsr_bits(32);
      rnd  = lfsr_bits(4);
      ahb_write({1'b0, rnd[3:0], off[1:0]}, hsize_t'(sz), data, resp);
      check_value("buffer write response", 32'd0, {31'd0, resp});
      check_value("buffer write wait states", 32'd0, seen_waits);
      check_value("buffer write store count", 32'd1, store_count);
      check_value("buffer write fetch count", 32'd0, get_count);
      // Lane data moved down to bit 0
      check_value("buffer write data", data >> (off * 8), seen_tx_data);
      check_value("buffer write size", sz, {30'd0, seen_size});
    end
  end
endtask

task automatic burst_write_test();
  for (int i = 0; i < 4; i++) begin
    burst_words[i] = lfsr_bits(32);
  end
  ahb_burst_write(7'h20);
  for (int i = 0; i < 4; i++) begin
    check_value("burst store strobe", 32'd1, {31'd0, beat_store[i]});
    check_value("burst data", burst_words[i], beat_tx[i]);
    check_value("burst response", 32'd0, {31'd0, beat_resp[i]});
  end
endtask

// Byte reads at each offset, then one word read
task automatic buffer_read_test();
  logic [31:0] word;
  logic [31:0] rnd;
  logic [31:0] rdata;
  logic        resp;
  for (int off = 0; off < 5; off++) begin
    word = lfsr_bits(32);
    rnd  = lfsr_bits(4);
    @(posedge tb_clk);
    rx_data_i <= word;
    if (off < 4) begin
      ahb_read({1'b0, rnd[3:0], off[1:0]}, SIZE_BYTE, rdata, resp);
      check_value("buffer byte read data", word << (off * 8), rdata);
    end else begin
      ahb_read({1'b0, rnd[3:0], 2'b00}, SIZE_WORD, rdata, resp);
      check_value("buffer word read data", word, rdata);
    end
    check_value("buffer read response", 32'd0, {31'd0, resp});
    check_value("buffer read wait states", 32'd0, seen_waits);
    check_value("buffer read fetch count", 32'd1, get_count);
    check_value("buffer read store count", 32'd0, store_count);
  end
endtask

task automatic status_read_test();
  logic [31:0] flags;
  logic [31:0] occ;
  logic [31:0] expected;
  logic [31:0] rdata;
  logic        resp;
  flags = lfsr_bits(5);
  occ   = lfsr_bits(7);
  @(posedge tb_clk);
  rx_data_ready_i      <= flags[0];
  rx_transfer_active_i <= flags[1];
  tx_transfer_active_i <= flags[2];
  rx_error_i           <= flags[3];
  tx_error_i           <= flags[4];
  buffer_occupancy_i   <= occ[`EP_OCC_W-1:0];
  // Status word from the field map
  expected = '0;
  expected[`EP_ST_RX_READY_BIT]  = flags[0];
  expected[`EP_ST_RX_ACTIVE_BIT] = flags[1];
  expected[`EP_ST_TX_ACTIVE_BIT] = flags[2];
  expected[`EP_ST_RX_ERR_BIT]    = flags[3];
  expected[`EP_ST_TX_ERR_BIT]    = flags[4];
  expected[`EP_ST_OCC_LSB +: `EP_OCC_W] = occ[`EP_OCC_W-1:0];
  ahb_read(`EP_STATUS_BASE, SIZE_WORD, rdata, resp);
  check_value("status read response", 32'd0, {31'd0, resp});
  check_value("status read data", expected, rdata);
  check_value("status read fetch count", 32'd0, get_count);
  // Quiet endpoint again for the size register test
  @(posedge tb_clk);
  rx_data_ready_i      <= 1'b0;
  rx_transfer_active_i <= 1'b0;
  tx_transfer_active_i <= 1'b0;
  rx_error_i           <= 1'b0;
  tx_error_i           <= 1'b0;
endtask

task automatic expect_error(input string name, input logic [`AHB_ADDR_W-1:0] addr,
                            input logic write, input hsize_t size);
  logic resp;
  ahb_transfer(addr, write, size, lfsr_bits(32), resp);
  check_value(name, 32'd1, {31'd0, resp});
  // Two-cycle response, first cycle holds HREADY low
  check_value({name, " wait states"}, 32'd1, seen_waits);
  check_value({name, " strobes"}, 32'd0, store_count + get_count);
endtask

task automatic error_response_test();
  expect_error("status write error", 7'h42, 1'b1, SIZE_BYTE);
  expect_error("unmapped read error", 7'h78, 1'b0, SIZE_WORD);
  expect_error("unmapped write error", 7'h46, 1'b1, SIZE_BYTE);
  expect_error("misaligned read error", 7'h01, 1'b0, SIZE_WORD);
  expect_error("dword size error", 7'h00, 1'b0, SIZE_DWORD);
  check_value("size after errors", 32'd0, {25'd0, tx_packet_data_size_o});
endtask

task automatic tx_size_test();
  logic [31:0] rdata;
  logic        resp;
  ahb_write(`EP_TX_SIZE_ADDR, SIZE_WORD, 32'd7, resp);
  check_value("tx size write response", 32'd0, {31'd0, resp});
  // Register loads at the edge ending the data phase
  @(posedge tb_clk);
  @(negedge tb_clk);
  check_value("tx size register", 32'd7, {25'd0, tx_packet_data_size_o});
  check_value("buffer reserved", 32'd1, {31'd0, buffer_reserved_o});
  ahb_read(`EP_TX_SIZE_ADDR, SIZE_WORD, rdata, resp);
  check_value("tx size read", 32'd7, rdata);
  // Outgoing transfer active for two cycles
  @(posedge tb_clk);
  tx_transfer_active_i <= 1'b1;
  repeat (2) @(posedge tb_clk);
  tx_transfer_active_i <= 1'b0;
  // Fall seen in the next cycle, cleared at its end
  @(posedge tb_clk);
  @(negedge tb_clk);
  check_value("reservation after transfer", 32'd0, {31'd0, buffer_reserved_o});
  check_value("tx size after transfer", 32'd0, {25'd0, tx_packet_data_size_o});
  ahb_read(`EP_TX_SIZE_ADDR, SIZE_WORD, rdata, resp);
  check_value("tx size read after transfer", 32'd0, rdata);
endtask

// File: dv/tb_ahb_endpoint.sv
// Testbench for the AHB-Lite USB endpoint slave
// Clock, reset, DUT, random source, value check and the directed test order

`timescale 1ns/100ps

`include "ahb_endpoint_macros.svh"

module tb_ahb_endpoint;

  import ahb_endpoint_pkg::*;

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TIMEOUT_CYCLES = 50;
  localparam logic [15:0] LFSR_SEED      = 16'd53252;

  // ******************************
  // DUT signals
  logic                   tb_clk;
  logic                   reset_i;
  logic                   hsel_i;
  logic [`AHB_ADDR_W-1:0] haddr_i;
  htrans_t                htrans_i;
  hsize_t                 hsize_i;
  logic                   hwrite_i;
  logic [`AHB_DATA_W-1:0] hwdata_i;
  logic [`AHB_DATA_W-1:0] hrdata_o;
  logic                   hready_o;
  logic                   hresp_o;
  logic                   rx_data_ready_i;
  logic                   rx_transfer_active_i;
  logic                   tx_transfer_active_i;
  logic                   rx_error_i;
  logic                   tx_error_i;
  logic [`EP_OCC_W-1:0]   buffer_occupancy_i;
  logic [`AHB_DATA_W-1:0] rx_data_i;
  logic                   store_tx_data_o;
  logic [`AHB_DATA_W-1:0] tx_data_o;
  logic [1:0]             data_size_o;
  logic                   get_rx_data_o;
  logic                   buffer_reserved_o;
  logic [`EP_OCC_W-1:0]   tx_packet_data_size_o;

  // What the last single transfer showed in its data phase
  int                     store_count;
  int                     get_count;
  int                     seen_waits;
  logic [`AHB_DATA_W-1:0] seen_rdata;
  logic [`AHB_DATA_W-1:0] seen_tx_data;
  logic [1:0]             seen_size;
  // Burst words and per-beat observations
  logic [`AHB_DATA_W-1:0] burst_words [4];
  logic [`AHB_DATA_W-1:0] beat_tx [4];
  logic                   beat_store [4];
  logic                   beat_resp [4];
  logic [15:0]            lfsr_q;

  ahb_endpoint_slave dut_i (.*);

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] lfsr_bits(input int nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                          name, expected, actual));
    end
  endtask

  `include "tb_ahb_endpoint_tasks.svh"

  // ******************************
  // Clock
  initial begin
    tb_clk = 1'b0;
    forever #(CLK_PERIOD / 2) tb_clk = ~tb_clk;
  end

  // ******************************
  // Test sequence
  initial begin
    lfsr_q               = LFSR_SEED;
    reset_i              = 1'b1;
    hsel_i               = 1'b0;
    haddr_i              = '0;
    htrans_i             = HTRANS_IDLE;
    hsize_i              = SIZE_BYTE;
    hwrite_i             = 1'b0;
    hwdata_i             = '0;
    rx_data_ready_i      = 1'b0;
    rx_transfer_active_i = 1'b0;
    tx_transfer_active_i = 1'b0;
    rx_error_i           = 1'b0;
    tx_error_i           = 1'b0;
    buffer_occupancy_i   = '0;
    rx_data_i            = '0;
    repeat (RESET_CYCLES) @(posedge tb_clk);
    reset_i <= 1'b0;

    reset_state_test();
    buffer_write_test();
    burst_write_test();
    buffer_read_test();
    status_read_test();
    error_response_test();
    tx_size_test();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: ahb_endpoint.f
+incdir+logic
+incdir+dv
logic/ahb_endpoint_pkg.sv
logic/ahb_addr_phase.sv
logic/ahb_resp_ctrl.sv
logic/endpoint_regs.sv
logic/ahb_endpoint_slave.sv
dv/tb_ahb_endpoint.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the endpoint slave testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/100ps -f ahb_endpoint.f \
  --top-module tb_ahb_endpoint -o tb_ahb_endpoint > sim.log 2>&1 \
  && ./obj_dir/tb_ahb_endpoint >> sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
